// ==== hdl/mem_types_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// requester-side types and widths
// access size codes, data widths
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package mem_types_pkg;

  // requester word and RAM word widths
  localparam int WORD_W = 32;
  localparam int HALF_W = 16;
  localparam int BYTE_W = 8;

  // access size as seen on the size port
  typedef enum logic [1:0] {
    access_byte = 2'b00,
    access_half = 2'b01,
    access_word = 2'b10  // two ram accesses
  } access_size_e;

endpackage

// ==== hdl/mem_ctrl_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// controller state and datapath selects
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package mem_ctrl_pkg;

  // msb set on store states
  typedef enum logic [3:0] {
    idle         = 4'b0000,
    load_half    = 4'b0001,
    load_byte    = 4'b0010,
    load_word_a  = 4'b0011,
    load_word_b  = 4'b0100,
    store_half   = 4'b1111,
    store_word_a = 4'b1101,
    store_word_b = 4'b1100,
    store_byte_a = 4'b1011,
    store_byte_b = 4'b1010
  } ctrl_state_e;

  // top sixteen bits of the load result
  typedef enum logic [1:0] {
    upper_zero      = 2'b00,
    upper_sign_half = 2'b01,
    upper_sign_byte = 2'b11,
    upper_ram       = 2'b10  // second half of a word
  } upper_sel_e;

  // low sixteen bits of the load result
  typedef enum logic [1:0] {
    lane_byte_sign = 2'b00,
    lane_byte_zero = 2'b01,
    lane_half      = 2'b10
  } lane_sel_e;

  // ram write data source
  typedef enum logic [1:0] {
    direct_low    = 2'b01,
    delayed_high  = 2'b10,
    delayed_merge = 2'b11  // byte over old halfword
  } wdata_sel_e;

  // ram address source
  typedef enum logic [1:0] {
    addr_request = 2'b00,
    addr_next    = 2'b01,
    addr_held    = 2'b10
  } addr_sel_e;

endpackage

// ==== hdl/mem_access_fsm.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// access controller FSM
// sequences ram cycles, drives selects and strobes
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module mem_access_fsm (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      load,
  input  logic                      store,
  input  mem_types_pkg::access_size_e size,
  input  logic                      is_signed,
  output logic                      ram_re,
  output logic                      ram_we,
  output mem_ctrl_pkg::addr_sel_e   addr_sel,
  output mem_ctrl_pkg::wdata_sel_e  wdata_sel,
  output logic                      remainder_new,
  output mem_ctrl_pkg::upper_sel_e  upper_sel,
  output mem_ctrl_pkg::lane_sel_e   lane_sel,
  output logic                      capture_low,
  output logic                      hold_req,
  output logic                      rdata_valid,
  output logic                      write_done,
  output logic                      busy
);

  import mem_types_pkg::*;
  import mem_ctrl_pkg::*;

  ctrl_state_e state;
  ctrl_state_e state_nxt;
  ctrl_state_e issue_state;  // first state of the requested access
  logic        sign_q;       // is_signed of the access in flight

  // shared decision for idle and every closing state
  function automatic ctrl_state_e next_access(input logic ld, input logic st,
                                              input access_size_e sz);
    ctrl_state_e res;
    res = idle;
    if (ld) begin
      case (sz)
        access_word: res = load_word_a;
        access_half: res = load_half;
        access_byte: res = load_byte;
        default:     res = idle;
      endcase
    end else if (st) begin
      case (sz)
        access_word: res = store_word_a;
        access_half: res = store_half;
        access_byte: res = store_byte_a;  // read old halfword first
        default:     res = idle;
      endcase
    end
    return res;
  endfunction

  assign issue_state = next_access(load, store, size);

  always_comb begin
    case (state)
      load_word_a:  state_nxt = load_word_b;
      store_word_a: state_nxt = store_word_b;
      store_byte_a: state_nxt = store_byte_b;
      default:      state_nxt = issue_state;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!reset) begin
      state  <= idle;
      sign_q <= 1'b0;
    end else begin
      state <= state_nxt;
      if (hold_req) sign_q <= is_signed;
    end
  end

  always_comb begin
    ram_re        = 1'b0;
    ram_we        = 1'b0;
    addr_sel      = addr_request;
    wdata_sel     = direct_low;
    remainder_new = 1'b1;
    upper_sel     = upper_zero;
    lane_sel      = lane_half;
    capture_low   = 1'b0;
    rdata_valid   = 1'b0;
    write_done    = 1'b0;
    busy          = 1'b0;
    case (state)
      load_half: begin
        rdata_valid = 1'b1;
        upper_sel   = sign_q ? upper_sign_half : upper_zero;
      end
      load_byte: begin
        rdata_valid = 1'b1;
        upper_sel   = sign_q ? upper_sign_byte : upper_zero;
        lane_sel    = sign_q ? lane_byte_sign : lane_byte_zero;
      end
      load_word_a: begin
        busy        = 1'b1;
        ram_re      = 1'b1;       // high halfword
        addr_sel    = addr_next;
        capture_low = 1'b1;       // low halfword on ram_dout now
      end
      load_word_b: begin
        rdata_valid = 1'b1;
        upper_sel   = upper_ram;
      end
      store_word_a: begin
        busy      = 1'b1;
        ram_we    = 1'b1;
        addr_sel  = addr_next;
        wdata_sel = delayed_high;
      end
      store_byte_a: begin
        busy          = 1'b1;
        ram_we        = 1'b1;
        addr_sel      = addr_held;
        wdata_sel     = delayed_merge;
        remainder_new = 1'b0;     // keep the other byte from ram
      end
      store_half, store_word_b, store_byte_b: begin
        write_done = 1'b1;
      end
      default: begin
      end
    endcase
    // first ram cycle of a new access
    if (!busy) begin
      ram_re = (issue_state == load_half) || (issue_state == load_byte) ||
               (issue_state == load_word_a) || (issue_state == store_byte_a);
      ram_we = (issue_state == store_half) || (issue_state == store_word_a);
    end
  end

  assign hold_req = (load || store) && !busy;

endmodule

// ==== hdl/mem_address_path.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// request address register and ram address select
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module mem_address_path #(
  parameter int ADDR_W = 9
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic [ADDR_W-1:0]       addr,
  input  logic                    hold_req,
  input  mem_ctrl_pkg::addr_sel_e addr_sel,
  output logic [ADDR_W-2:0]       ram_addr,
  output logic                    byte_lane
);

  import mem_ctrl_pkg::*;

  logic [ADDR_W-2:0] half_addr_q;  // halfword address of the access
  logic              lane_q;

  always_ff @(posedge clk) begin
    if (!reset) begin
      half_addr_q <= '0;
      lane_q      <= 1'b0;
    end else if (hold_req) begin
      half_addr_q <= addr[ADDR_W-1:1];
      lane_q      <= addr[0];
    end
  end

  always_comb begin
    case (addr_sel)
      addr_next: ram_addr = half_addr_q + 1'b1;  // wraps at the top
      addr_held: ram_addr = half_addr_q;
      default:   ram_addr = addr[ADDR_W-1:1];    // live request
    endcase
  end

  assign byte_lane = lane_q;

endmodule

// ==== hdl/store_data_path.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// store data register and ram write halfword
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module store_data_path (
  input  logic                             clk,
  input  logic                             reset,
  input  logic [mem_types_pkg::WORD_W-1:0] wdata,
  input  logic                             hold_req,
  input  mem_ctrl_pkg::wdata_sel_e         wdata_sel,
  input  logic                             remainder_new,
  input  logic                             byte_lane,
  input  logic [mem_types_pkg::HALF_W-1:0] ram_dout,
  output logic [mem_types_pkg::HALF_W-1:0] ram_din
);

  import mem_types_pkg::*;
  import mem_ctrl_pkg::*;

  logic [WORD_W-1:0] wdata_q;
  logic [BYTE_W-1:0] new_byte;
  logic [BYTE_W-1:0] rest_byte;  // byte beside the stored one

  always_ff @(posedge clk) begin
    if (!reset) wdata_q <= '0;
    else if (hold_req) wdata_q <= wdata;
  end

  assign new_byte = wdata_q[BYTE_W-1:0];

  // old remainder is the untouched lane of the read halfword
  assign rest_byte = remainder_new ? wdata_q[HALF_W-1:BYTE_W] :
                     byte_lane     ? ram_dout[BYTE_W-1:0] : ram_dout[HALF_W-1:BYTE_W];

  always_comb begin
    case (wdata_sel)
      delayed_high:  ram_din = wdata_q[WORD_W-1:HALF_W];
      delayed_merge: ram_din = byte_lane ? {new_byte, rest_byte} : {rest_byte, new_byte};
      default:       ram_din = wdata[HALF_W-1:0];  // first half, same cycle
    endcase
  end

endmodule

// ==== hdl/load_data_path.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// load result assembly
// low halfword register, lane pick, sign/zero fill
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module load_data_path (
  input  logic                             clk,
  input  logic                             reset,
  input  logic [mem_types_pkg::HALF_W-1:0] ram_dout,
  input  logic                             capture_low,
  input  logic                             byte_lane,
  input  mem_ctrl_pkg::upper_sel_e         upper_sel,
  input  mem_ctrl_pkg::lane_sel_e          lane_sel,
  output logic [mem_types_pkg::WORD_W-1:0] rdata
);

  import mem_types_pkg::*;
  import mem_ctrl_pkg::*;

  logic [HALF_W-1:0] low_q;      // first halfword of a word load
  logic [BYTE_W-1:0] lane_byte;
  logic [HALF_W-1:0] half_src;
  logic [HALF_W-1:0] low_part;
  logic [HALF_W-1:0] high_part;

  always_ff @(posedge clk) begin
    if (!reset) low_q <= '0;
    else if (capture_low) low_q <= ram_dout;
  end

  assign lane_byte = byte_lane ? ram_dout[HALF_W-1:BYTE_W] : ram_dout[BYTE_W-1:0];

  // word load takes its low half from the register
  assign half_src = (upper_sel == upper_ram) ? low_q : ram_dout;

  always_comb begin
    case (lane_sel)
      lane_byte_sign: low_part = {{BYTE_W{lane_byte[BYTE_W-1]}}, lane_byte};
      lane_byte_zero: low_part = {{BYTE_W{1'b0}}, lane_byte};
      default:        low_part = half_src;
    endcase
  end

  always_comb begin
    case (upper_sel)
      upper_sign_half: high_part = {HALF_W{ram_dout[HALF_W-1]}};
      upper_sign_byte: high_part = {HALF_W{lane_byte[BYTE_W-1]}};
      upper_ram:       high_part = ram_dout;  // high halfword just read
      default:         high_part = '0;
    endcase
  end

  assign rdata = {high_part, low_part};

endmodule

// ==== hdl/halfword_ram.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// single-port 16-bit RAM, registered read
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module halfword_ram #(
  parameter int ADDR_W    = 9,
  parameter int RAM_DEPTH = 256
) (
  input  logic                             clk,
  input  logic                             re,
  input  logic                             we,
  input  logic [ADDR_W-2:0]                addr,  // halfword address
  input  logic [mem_types_pkg::HALF_W-1:0] din,
  output logic [mem_types_pkg::HALF_W-1:0] dout
);

  import mem_types_pkg::*;

  logic [HALF_W-1:0] mem [RAM_DEPTH];

  always_ff @(posedge clk) begin
    if (we) mem[addr] <= din;
    if (re) dout <= mem[addr];  // valid the cycle after re
  end

endmodule

// ==== hdl/mem_access_unit.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// memory access unit top level
// 32-bit requester over a 16-bit synchronous RAM
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module mem_access_unit #(
  parameter int ADDR_W    = 9,
  parameter int RAM_DEPTH = 256
) (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             load,
  input  logic                             store,
  input  mem_types_pkg::access_size_e      size,
  input  logic                             is_signed,
  input  logic [ADDR_W-1:0]                addr,
  input  logic [mem_types_pkg::WORD_W-1:0] wdata,
  output logic [mem_types_pkg::WORD_W-1:0] rdata,
  output logic                             rdata_valid,
  output logic                             write_done,
  output logic                             busy
);

  import mem_types_pkg::*;
  import mem_ctrl_pkg::*;

  logic              ram_re;
  logic              ram_we;
  addr_sel_e         addr_sel;
  wdata_sel_e        wdata_sel;
  logic              remainder_new;
  upper_sel_e        upper_sel;
  lane_sel_e         lane_sel;
  logic              capture_low;
  logic              hold_req;
  logic [ADDR_W-2:0] ram_addr;
  logic              byte_lane;
  logic [HALF_W-1:0] ram_din;
  logic [HALF_W-1:0] ram_dout;

  mem_access_fsm u_mem_access_fsm (
    .clk           (clk),
    .reset         (reset),
    .load          (load),
    .store         (store),
    .size          (size),
    .is_signed     (is_signed),
    .ram_re        (ram_re),
    .ram_we        (ram_we),
    .addr_sel      (addr_sel),
    .wdata_sel     (wdata_sel),
    .remainder_new (remainder_new),
    .upper_sel     (upper_sel),
    .lane_sel      (lane_sel),
    .capture_low   (capture_low),
    .hold_req      (hold_req),
    .rdata_valid   (rdata_valid),
    .write_done    (write_done),
    .busy          (busy)
  );

  mem_address_path #(
    .ADDR_W (ADDR_W)
  ) u_mem_address_path (
    .clk       (clk),
    .reset     (reset),
    .addr      (addr),
    .hold_req  (hold_req),
    .addr_sel  (addr_sel),
    .ram_addr  (ram_addr),
    .byte_lane (byte_lane)
  );

  store_data_path u_store_data_path (
    .clk           (clk),
    .reset         (reset),
    .wdata         (wdata),
    .hold_req      (hold_req),
    .wdata_sel     (wdata_sel),
    .remainder_new (remainder_new),
    .byte_lane     (byte_lane),
    .ram_dout      (ram_dout),
    .ram_din       (ram_din)
  );

  load_data_path u_load_data_path (
    .clk         (clk),
    .reset       (reset),
    .ram_dout    (ram_dout),
    .capture_low (capture_low),
    .byte_lane   (byte_lane),
    .upper_sel   (upper_sel),
    .lane_sel    (lane_sel),
    .rdata       (rdata)
  );

  halfword_ram #(
    .ADDR_W    (ADDR_W),
    .RAM_DEPTH (RAM_DEPTH)
  ) u_halfword_ram (
    .clk  (clk),
    .re   (ram_re),
    .we   (ram_we),
    .addr (ram_addr),
    .din  (ram_din),
    .dout (ram_dout)
  );

endmodule

// ==== tb/mem_access_props.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// request and strobe protocol assertions
// bound to mem_access_unit
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module mem_access_props (
  input logic clk,
  input logic reset,
  input logic load,
  input logic store,
  input logic busy,
  input logic rdata_valid,
  input logic write_done
);

  int unsigned fail_count = 0;  // count of failed assertions

  no_dual_request: assert property (@(posedge clk) disable iff (!reset) !(load && store))
    else begin
      fail_count++;
      $error("load and store raised in the same cycle");
    end

  no_request_while_busy: assert property (@(posedge clk) disable iff (!reset)
                                          busy |-> !(load || store))
    else begin
      fail_count++;
      $error("request raised while busy");
    end

  busy_one_cycle: assert property (@(posedge clk) disable iff (!reset) busy |=> !busy)
    else begin
      fail_count++;
      $error("busy high for two cycles running");
    end

  pulses_exclusive: assert property (@(posedge clk) disable iff (!reset)
                                     !(rdata_valid && write_done))
    else begin
      fail_count++;
      $error("rdata_valid and write_done high together");
    end

endmodule

bind mem_access_unit mem_access_props u_mem_access_props (
  .clk         (clk),
  .reset       (reset),
  .load        (load),
  .store       (store),
  .busy        (busy),
  .rdata_valid (rdata_valid),
  .write_done  (write_done)
);

// ==== tb/tb_mem_access_unit.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for mem_access_unit
// LFSR random accesses, byte model, per-cycle checks
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module tb_mem_access_unit;

  import mem_types_pkg::*;

  localparam int ADDR_W         = 7;
  localparam int RAM_DEPTH      = 64;
  localparam int NUM_BYTES      = 2 * RAM_DEPTH;
  localparam int CLK_PERIOD     = 20;
  localparam int RESET_CYCLES   = 10;
  localparam int INIT_OPS       = NUM_BYTES / 2;  // word stores, then word loads
  localparam int RANDOM_OPS     = 600;
  localparam int SLACK_CYCLES   = 20;
  localparam int TIMEOUT_CYCLES = (INIT_OPS + RANDOM_OPS) * 3 + RESET_CYCLES + SLACK_CYCLES;

  logic              clk;
  logic              reset;
  logic              load;
  logic              store;
  access_size_e      size;
  logic              is_signed;
  logic [ADDR_W-1:0] addr;
  logic [WORD_W-1:0] wdata;
  logic [WORD_W-1:0] rdata;
  logic              rdata_valid;
  logic              write_done;
  logic              busy;

  logic [31:0]       lfsr;
  int                cyc;                    // index of the cycle after the last edge
  logic [BYTE_W-1:0] model_mem [NUM_BYTES];  // little endian byte image of the RAM
  logic              exp_valid [4];
  logic              exp_done  [4];
  logic              exp_busy  [4];
  logic [WORD_W-1:0] exp_rdata [4];

  mem_access_unit #(
    .ADDR_W    (ADDR_W),
    .RAM_DEPTH (RAM_DEPTH)
  ) u_mem_access_unit (
    .clk         (clk),
    .reset       (reset),
    .load        (load),
    .store       (store),
    .size        (size),
    .is_signed   (is_signed),
    .addr        (addr),
    .wdata       (wdata),
    .rdata       (rdata),
    .rdata_valid (rdata_valid),
    .write_done  (write_done),
    .busy        (busy)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] st);
    logic fb;
    fb = st[31] ^ st[21] ^ st[1] ^ st[0];
    return {st[30:0], fb};
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      val  = {val[30:0], lfsr[0]};  // one step per bit
    end
  endtask

  task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    if (got !== exp) begin
      $display("[FAIL] %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      $display("Verification failed");
      $fatal(1, "value mismatch");
    end
  endtask

  function automatic int byte_index(input logic [ADDR_W-1:0] a, input int offset);
    return (int'(a) + offset) % NUM_BYTES;  // word high half wraps
  endfunction

  // model update and expected pulses for a request accepted at the next edge
  task automatic predict(input logic ld, input access_size_e sz, input logic sg,
                         input logic [ADDR_W-1:0] ad, input logic [WORD_W-1:0] wd);
    int                a;
    int                b;
    logic [ADDR_W-1:0] even_ad;
    logic [15:0]       h;
    logic [7:0]        bt;
    a       = (cyc + 1) % 4;
    b       = (cyc + 2) % 4;
    even_ad = {ad[ADDR_W-1:1], 1'b0};
    h       = {model_mem[byte_index(even_ad, 1)], model_mem[byte_index(even_ad, 0)]};
    bt      = model_mem[byte_index(ad, 0)];
    if (ld) begin
      case (sz)
        access_word: begin
          exp_busy[a]  = 1'b1;
          exp_valid[b] = 1'b1;
          exp_rdata[b] = {model_mem[byte_index(even_ad, 3)],
                          model_mem[byte_index(even_ad, 2)], h};
        end
        access_half: begin
          exp_valid[a] = 1'b1;
          exp_rdata[a] = sg ? {{16{h[15]}}, h} : {16'h0000, h};
        end
        default: begin
          exp_valid[a] = 1'b1;
          exp_rdata[a] = sg ? {{24{bt[7]}}, bt} : {24'h000000, bt};
        end
      endcase
    end else begin
      case (sz)
        access_word: begin
          for (int i = 0; i < 4; i++) begin
            model_mem[byte_index(even_ad, i)] = wd[8*i +: 8];
          end
          exp_busy[a] = 1'b1;
          exp_done[b] = 1'b1;
        end
        access_half: begin
          model_mem[byte_index(even_ad, 0)] = wd[7:0];
          model_mem[byte_index(even_ad, 1)] = wd[15:8];
          exp_done[a] = 1'b1;
        end
        default: begin
          model_mem[byte_index(ad, 0)] = wd[7:0];  // other lane untouched
          exp_busy[a] = 1'b1;
          exp_done[b] = 1'b1;
        end
      endcase
    end
  endtask

  // drive one cycle, then check the outputs of the cycle that just began
  task automatic cycle_step(input logic ld, input logic st, input access_size_e sz,
                            input logic sg, input logic [ADDR_W-1:0] ad,
                            input logic [WORD_W-1:0] wd);
    int s;
    @(posedge clk);
    load      <= ld;
    store     <= st;
    size      <= sz;
    is_signed <= sg;
    addr      <= ad;
    wdata     <= wd;
    cyc = cyc + 1;
    if (ld || st) predict(ld, sz, sg, ad, wd);
    @(negedge clk);
    s = cyc % 4;
    check_equal(busy, exp_busy[s], "busy");
    check_equal(rdata_valid, exp_valid[s], "rdata_valid");
    check_equal(write_done, exp_done[s], "write_done");
    if (exp_valid[s]) check_equal(rdata, exp_rdata[s], $sformatf("load data, cycle %0d", cyc));
    check_equal(u_mem_access_unit.u_mem_access_props.fail_count, 0,
                "protocol assertion failures");
    exp_busy[s]  = 1'b0;
    exp_valid[s] = 1'b0;
    exp_done[s]  = 1'b0;
  endtask

  task automatic idle_step();
    cycle_step(1'b0, 1'b0, access_byte, 1'b0, '0, '0);
  endtask

  task automatic run_access(input logic ld, input access_size_e sz, input logic sg,
                            input logic [ADDR_W-1:0] ad, input logic [WORD_W-1:0] wd);
    cycle_step(ld, !ld, sz, sg, ad, wd);
    if (sz == access_word || (!ld && sz == access_byte)) idle_step();  // busy cycle
  endtask

  initial begin
    logic [31:0]  r;
    logic [31:0]  kind;
    logic [31:0]  sz_bits;
    logic [31:0]  sg;
    logic [31:0]  ad;
    access_size_e sz;
    clk       = 1'b0;
    reset     = 1'b0;
    load      = 1'b0;
    store     = 1'b0;
    size      = access_byte;
    is_signed = 1'b0;
    addr      = '0;
    wdata     = '0;
    lfsr      = 32'h4c72;
    cyc       = 0;
    for (int i = 0; i < 4; i++) begin
      exp_busy[i]  = 1'b0;
      exp_valid[i] = 1'b0;
      exp_done[i]  = 1'b0;
      exp_rdata[i] = '0;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b1;
    repeat (3) idle_step();  // quiet outputs before any request
    for (int a = 0; a < NUM_BYTES; a += 4) begin
      draw_bits(32, r);
      run_access(1'b0, access_word, 1'b0, ADDR_W'(a), r);
    end
    for (int a = 0; a < NUM_BYTES; a += 4) begin
      run_access(1'b1, access_word, 1'b0, ADDR_W'(a), '0);
    end
    for (int n = 0; n < RANDOM_OPS; n++) begin
      draw_bits(2, kind);
      draw_bits(2, sz_bits);
      draw_bits(1, sg);
      draw_bits(ADDR_W, ad);
      draw_bits(32, r);
      sz = (sz_bits == 0) ? access_byte : (sz_bits == 1) ? access_half : access_word;
      if (kind == 0) idle_step();
      else run_access(kind[0], sz, sg[0], ad[ADDR_W-1:0], r);  // odd kinds load
    end
    repeat (3) idle_step();
    $display("Verification passed");
    $finish;
  end

  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, the run did not complete", TIMEOUT_CYCLES);
    $display("Verification failed");
    $fatal(1, "timeout");
  end

endmodule

// ==== src.f ====
hdl/mem_types_pkg.sv
hdl/mem_ctrl_pkg.sv
hdl/mem_access_fsm.sv
hdl/mem_address_path.sv
hdl/store_data_path.sv
hdl/load_data_path.sv
hdl/halfword_ram.sv
hdl/mem_access_unit.sv
tb/mem_access_props.sv
tb/tb_mem_access_unit.sv
